// ==== logic/rl_axil_csr.sv ====
// AXI4-Lite slave: control register with enable and clear, read access to the statistics
`default_nettype none

module rl_axil_csr
  import rl_noc_pkg::*;
  import rl_csr_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     reset_i,

  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [RL_CSR_ADDR_W-1:0] awaddr_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  logic [31:0]              wdata_i,
  input  logic [3:0]               wstrb_i,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output rl_axi_resp_e             bresp_o,

  input  logic                     arvalid_i,
  output logic                     arready_o,
  input  logic [RL_CSR_ADDR_W-1:0] araddr_i,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output logic [31:0]              rdata_o,
  output rl_axi_resp_e             rresp_o,

  output logic                     enable_o,
  output logic                     clear_o,
  output rl_kind_e                 rd_kind_o,
  input  logic [31:0]              count_i,
  input  logic [31:0]              sum_i,
  input  logic [31:0]              max_i,
  input  logic [31:0]              maxdest_i
);

  logic         enable_r;
  logic         clear_r;
  logic         bvalid_r;
  rl_axi_resp_e bresp_r;
  logic         rvalid_r;
  logic [31:0]  rdata_r;
  rl_axi_resp_e rresp_r;

  logic                     wr_fire;
  logic                     wr_ctrl;
  logic                     rd_fire;
  logic [RL_CSR_ADDR_W-1:0] rd_ofs;
  logic [31:0]              rd_data;
  rl_axi_resp_e             rd_resp;

  // word-aligned register inside one of the per-kind blocks
  function automatic logic is_stat_addr(input logic [RL_CSR_ADDR_W-1:0] addr);
    logic [RL_CSR_ADDR_W-1:0] ofs;
    ofs = addr - RL_CSR_STATS_BASE;
    return (addr >= RL_CSR_STATS_BASE) &&
           (int'(ofs[RL_CSR_ADDR_W-1:RL_CSR_KIND_LSB]) < RL_NUM_KINDS) &&
           (ofs[1:0] == 2'b00);
  endfunction

  // write channel, address and data must arrive together
  assign awready_o = !bvalid_r;
  assign wready_o  = !bvalid_r;
  assign wr_fire   = awvalid_i && wvalid_i && !bvalid_r;
  assign wr_ctrl   = wr_fire && (awaddr_i == RL_CSR_CTRL) && wstrb_i[0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bvalid_r <= 1'b0;
      enable_r <= 1'b0;
      clear_r  <= 1'b0;
    end else begin
      if (wr_fire) begin
        bvalid_r <= 1'b1;
      end else if (bready_i) begin
        bvalid_r <= 1'b0;
      end
      if (wr_ctrl) begin
        enable_r <= wdata_i[RL_CTRL_ENABLE_BIT];
      end
      // one-cycle pulse, high while the write response is out
      clear_r <= wr_ctrl && wdata_i[RL_CTRL_CLEAR_BIT];
    end
  end

  // statistics are read-only, writes there are ignored but still OKAY
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      if ((awaddr_i == RL_CSR_CTRL) || is_stat_addr(awaddr_i)) begin
        bresp_r <= RL_AXI_OKAY;
      end else begin
        bresp_r <= RL_AXI_SLVERR;
      end
    end
  end

  // read channel
  assign arready_o = !rvalid_r;
  assign rd_fire   = arvalid_i && !rvalid_r;
  assign rd_ofs    = araddr_i - RL_CSR_STATS_BASE;
  assign rd_kind_o = rl_kind_e'(rd_ofs[RL_CSR_KIND_LSB +: $bits(rl_kind_e)]);

  always_comb begin
    rd_data = '0;
    rd_resp = RL_AXI_OKAY;
    if (araddr_i == RL_CSR_CTRL) begin
      rd_data[RL_CTRL_ENABLE_BIT] = enable_r;
    end else if (is_stat_addr(araddr_i)) begin
      case (rd_ofs[RL_CSR_KIND_LSB-1:0])
        RL_CSR_COUNT_OFS:   rd_data = count_i;
        RL_CSR_SUM_OFS:     rd_data = sum_i;
        RL_CSR_MAX_OFS:     rd_data = max_i;
        RL_CSR_MAXDEST_OFS: rd_data = maxdest_i;
        default:            rd_data = '0;
      endcase
    end else begin
      rd_resp = RL_AXI_SLVERR;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_r <= 1'b0;
    end else if (rd_fire) begin
      rvalid_r <= 1'b1;
    end else if (rready_i) begin
      rvalid_r <= 1'b0;
    end
  end

  // captured at the AR handshake so data stays fixed while the master stalls
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      rdata_r <= rd_data;
      rresp_r <= rd_resp;
    end
  end

  assign bvalid_o = bvalid_r;
  assign bresp_o  = bresp_r;
  assign rvalid_o = rvalid_r;
  assign rdata_o  = rdata_r;
  assign rresp_o  = rresp_r;
  assign enable_o = enable_r;
  assign clear_o  = clear_r;

endmodule

`default_nettype wire

// ==== logic/rl_csr_pkg.sv ====
// register map offsets, control bit positions, maxdest layout and AXI response enum
`default_nettype none

package rl_csr_pkg;

  localparam int RL_CSR_ADDR_W = 8;

  // control register
  localparam logic [RL_CSR_ADDR_W-1:0] RL_CSR_CTRL = 8'h00;
  localparam int RL_CTRL_ENABLE_BIT = 0;
  // write-only, reads back as zero
  localparam int RL_CTRL_CLEAR_BIT = 1;

  // per-kind blocks start here, one 16-byte block per kind
  localparam logic [RL_CSR_ADDR_W-1:0] RL_CSR_STATS_BASE = 8'h10;
  localparam int RL_CSR_KIND_LSB = 4;

  // register offsets inside one kind block
  localparam logic [3:0] RL_CSR_COUNT_OFS   = 4'h0;
  localparam logic [3:0] RL_CSR_SUM_OFS     = 4'h4;
  localparam logic [3:0] RL_CSR_MAX_OFS     = 4'h8;
  localparam logic [3:0] RL_CSR_MAXDEST_OFS = 4'hC;

  // maxdest packs x in 15:8 and y in 7:0
  localparam int RL_MAXDEST_X_LSB = 8;
  localparam int RL_MAXDEST_Y_LSB = 0;

  typedef enum logic [1:0] {
    RL_AXI_OKAY   = 2'b00,
    RL_AXI_SLVERR = 2'b10
  } rl_axi_resp_e;

endpackage

`default_nettype wire

// ==== logic/rl_latency_stats.sv ====
// per-kind latency statistics: count, sum, maximum and destination of the maximum, with clear
`default_nettype none

module rl_latency_stats
  import rl_noc_pkg::*;
  import rl_csr_pkg::*;
#(
  parameter int X_W   = 8,
  parameter int Y_W   = 8,
  parameter int LAT_W = 16
) (
  input  logic         clk_i,
  input  logic         reset_i,
  input  logic         clear_i,

  rl_sample_if.consumer sample_i,

  input  rl_kind_e     rd_kind_i,
  output logic [31:0]  count_o,
  output logic [31:0]  sum_o,
  output logic [31:0]  max_o,
  output logic [31:0]  maxdest_o
);

  logic [31:0]      count_r [RL_NUM_KINDS];
  logic [31:0]      sum_r [RL_NUM_KINDS];
  logic [LAT_W-1:0] max_r [RL_NUM_KINDS];
  logic [X_W-1:0]   max_x_r [RL_NUM_KINDS];
  logic [Y_W-1:0]   max_y_r [RL_NUM_KINDS];

  logic [1:0] smp_idx;
  logic       smp_ok;
  logic [1:0] rd_idx;
  logic       rd_ok;

  assign smp_idx = sample_i.kind;
  assign smp_ok  = sample_i.valid && (int'(smp_idx) < RL_NUM_KINDS);

  // clear wins over a sample landing in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i || clear_i) begin
      for (int k = 0; k < RL_NUM_KINDS; k++) begin
        count_r[k] <= '0;
        sum_r[k]   <= '0;
        max_r[k]   <= '0;
        max_x_r[k] <= '0;
        max_y_r[k] <= '0;
      end
    end else if (smp_ok) begin
      count_r[smp_idx] <= count_r[smp_idx] + 32'd1;
      sum_r[smp_idx]   <= sum_r[smp_idx] + 32'(sample_i.latency);
      // strictly greater, ties keep the earlier destination
      if (sample_i.latency > max_r[smp_idx]) begin
        max_r[smp_idx]   <= sample_i.latency;
        max_x_r[smp_idx] <= sample_i.dest_x;
        max_y_r[smp_idx] <= sample_i.dest_y;
      end
    end
  end

  assign rd_idx = rd_kind_i;
  assign rd_ok  = int'(rd_idx) < RL_NUM_KINDS;

  // selected kind, presented combinationally to the register slave
  always_comb begin
    count_o   = '0;
    sum_o     = '0;
    max_o     = '0;
    maxdest_o = '0;
    if (rd_ok) begin
      count_o                              = count_r[rd_idx];
      sum_o                                = sum_r[rd_idx];
      max_o[LAT_W-1:0]                     = max_r[rd_idx];
      maxdest_o[RL_MAXDEST_X_LSB +: X_W]   = max_x_r[rd_idx];
      maxdest_o[RL_MAXDEST_Y_LSB +: Y_W]   = max_y_r[rd_idx];
    end
  end

endmodule

`default_nettype wire

// ==== logic/rl_launch_tracker.sv ====
// launch tracker: cycle counter, launch classification, start-cycle tables, latency on response
`default_nettype none

module rl_launch_tracker
  import rl_noc_pkg::*;
#(
  parameter int REG_ELS = 32,
  parameter int X_W     = 8,
  parameter int Y_W     = 8,
  parameter int LAT_W   = 16,
  localparam int REG_ID_W = $clog2(REG_ELS)
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                enable_i,

  input  logic                launch_v_i,
  input  rl_op_e              launch_op_i,
  input  logic                launch_float_wb_i,
  input  logic                launch_icache_i,
  input  logic [REG_ID_W-1:0] launch_reg_id_i,
  input  logic [X_W-1:0]      launch_dest_x_i,
  input  logic [Y_W-1:0]      launch_dest_y_i,

  input  logic                ret_v_i,
  input  logic                ret_yumi_i,
  input  rl_ret_e             ret_type_i,
  input  logic [REG_ID_W-1:0] ret_reg_id_i,

  rl_sample_if.producer       sample_o
);

  localparam int CTR_W = 32;

  typedef struct packed {
    logic [CTR_W-1:0] start_cycle;
    logic [X_W-1:0]   dest_x;
    logic [Y_W-1:0]   dest_y;
  } entry_t;

  logic [CTR_W-1:0] ctr_r;

  entry_t int_tab_r [REG_ELS];
  entry_t float_tab_r [REG_ELS];
  entry_t icache_r;
  entry_t next_entry;

  logic is_load;
  logic int_v;
  logic float_v;
  logic icache_v;

  logic             ret_fire;
  logic             hit_v;
  rl_kind_e         hit_kind;
  entry_t           hit_entry;
  logic [CTR_W-1:0] elapsed;
  logic [LAT_W-1:0] lat_sat;

  // free-running, wraps at 32 bits which the subtraction tolerates
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ctr_r <= '0;
    end else begin
      ctr_r <= ctr_r + 1'b1;
    end
  end

  // classification, amo always counts as an integer load
  assign is_load  = (launch_op_i == RL_OP_LOAD);
  assign int_v    = launch_v_i &&
                    ((is_load && !launch_icache_i && !launch_float_wb_i) ||
                     (launch_op_i == RL_OP_AMO));
  assign float_v  = launch_v_i && is_load && launch_float_wb_i;
  assign icache_v = launch_v_i && is_load && launch_icache_i;

  assign next_entry = '{start_cycle: ctr_r, dest_x: launch_dest_x_i, dest_y: launch_dest_y_i};

  // start cycles are recorded regardless of enable
  always_ff @(posedge clk_i) begin
    if (int_v) begin
      int_tab_r[launch_reg_id_i] <= next_entry;
    end
    if (float_v) begin
      float_tab_r[launch_reg_id_i] <= next_entry;
    end
    if (icache_v) begin
      icache_r <= next_entry;
    end
  end

  assign ret_fire = ret_v_i && ret_yumi_i;

  // entry lookup by return type, credits carry no load
  always_comb begin
    hit_v     = 1'b1;
    hit_kind  = RL_KIND_INT;
    hit_entry = int_tab_r[ret_reg_id_i];
    case (ret_type_i)
      RL_RET_INT_WB: begin
        hit_kind  = RL_KIND_INT;
        hit_entry = int_tab_r[ret_reg_id_i];
      end
      RL_RET_FLOAT_WB: begin
        hit_kind  = RL_KIND_FLOAT;
        hit_entry = float_tab_r[ret_reg_id_i];
      end
      RL_RET_IFETCH: begin
        hit_kind  = RL_KIND_ICACHE;
        hit_entry = icache_r;
      end
      default: begin
        hit_v = 1'b0;
      end
    endcase
  end

  assign elapsed = ctr_r - hit_entry.start_cycle;
  // saturate anything that does not fit in LAT_W
  assign lat_sat = (|elapsed[CTR_W-1:LAT_W]) ? {LAT_W{1'b1}} : elapsed[LAT_W-1:0];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sample_o.valid <= 1'b0;
    end else begin
      sample_o.valid <= ret_fire && hit_v && enable_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ret_fire) begin
      sample_o.kind    <= hit_kind;
      sample_o.latency <= lat_sat;
      sample_o.dest_x  <= hit_entry.dest_x;
      sample_o.dest_y  <= hit_entry.dest_y;
    end
  end

endmodule

`default_nettype wire

// ==== logic/rl_noc_pkg.sv ====
// network-side enums for request opcode, return packet type and load kind, plus kind count
`default_nettype none

package rl_noc_pkg;

  // opcode of an outgoing network request
  typedef enum logic [1:0] {
    RL_OP_LOAD  = 2'd0,
    RL_OP_STORE = 2'd1,
    RL_OP_AMO   = 2'd2
  } rl_op_e;

  // type of a returning response packet
  typedef enum logic [1:0] {
    RL_RET_INT_WB   = 2'd0,
    RL_RET_FLOAT_WB = 2'd1,
    RL_RET_IFETCH   = 2'd2,
    RL_RET_CREDIT   = 2'd3
  } rl_ret_e;

  // profiled load kinds, also the index into the statistics arrays
  typedef enum logic [1:0] {
    RL_KIND_INT    = 2'd0,
    RL_KIND_FLOAT  = 2'd1,
    RL_KIND_ICACHE = 2'd2
  } rl_kind_e;

  // number of kinds that keep their own statistics
  localparam int RL_NUM_KINDS = 3;

endpackage

`default_nettype wire

// ==== logic/rl_profiler_top.sv ====
// profiler top level: launch tracker, latency statistics and AXI4-Lite register slave
`default_nettype none

module rl_profiler_top
  import rl_noc_pkg::*;
  import rl_csr_pkg::*;
#(
  parameter int REG_ELS = 32,
  parameter int X_W     = 8,
  parameter int Y_W     = 8,
  parameter int LAT_W   = 16,
  localparam int REG_ID_W = $clog2(REG_ELS)
) (
  input  logic                     clk_i,
  input  logic                     reset_i,

  // network observation
  input  logic                     launch_v_i,
  input  rl_op_e                   launch_op_i,
  input  logic                     launch_float_wb_i,
  input  logic                     launch_icache_i,
  input  logic [REG_ID_W-1:0]      launch_reg_id_i,
  input  logic [X_W-1:0]           launch_dest_x_i,
  input  logic [Y_W-1:0]           launch_dest_y_i,
  input  logic                     ret_v_i,
  input  logic                     ret_yumi_i,
  input  rl_ret_e                  ret_type_i,
  input  logic [REG_ID_W-1:0]      ret_reg_id_i,

  // host AXI4-Lite
  input  logic                     awvalid_i,
  output logic                     awready_o,
  input  logic [RL_CSR_ADDR_W-1:0] awaddr_i,
  input  logic                     wvalid_i,
  output logic                     wready_o,
  input  logic [31:0]              wdata_i,
  input  logic [3:0]               wstrb_i,
  output logic                     bvalid_o,
  input  logic                     bready_i,
  output rl_axi_resp_e             bresp_o,
  input  logic                     arvalid_i,
  output logic                     arready_o,
  input  logic [RL_CSR_ADDR_W-1:0] araddr_i,
  output logic                     rvalid_o,
  input  logic                     rready_i,
  output logic [31:0]              rdata_o,
  output rl_axi_resp_e             rresp_o
);

  logic        enable;
  logic        clear;
  rl_kind_e    rd_kind;
  logic [31:0] count;
  logic [31:0] sum;
  logic [31:0] max;
  logic [31:0] maxdest;

  rl_sample_if #(.X_W(X_W), .Y_W(Y_W), .LAT_W(LAT_W)) sample_if ();

  rl_launch_tracker #(
    .REG_ELS(REG_ELS), .X_W(X_W), .Y_W(Y_W), .LAT_W(LAT_W)
  ) u_tracker (
    .clk_i, .reset_i, .enable_i(enable),
    .launch_v_i, .launch_op_i, .launch_float_wb_i, .launch_icache_i,
    .launch_reg_id_i, .launch_dest_x_i, .launch_dest_y_i,
    .ret_v_i, .ret_yumi_i, .ret_type_i, .ret_reg_id_i,
    .sample_o(sample_if.producer)
  );

  rl_latency_stats #(.X_W(X_W), .Y_W(Y_W), .LAT_W(LAT_W)) u_stats (
    .clk_i, .reset_i, .clear_i(clear),
    .sample_i(sample_if.consumer),
    .rd_kind_i(rd_kind),
    .count_o(count), .sum_o(sum), .max_o(max), .maxdest_o(maxdest)
  );

  rl_axil_csr u_csr (
    .clk_i, .reset_i,
    .awvalid_i, .awready_o, .awaddr_i, .wvalid_i, .wready_o, .wdata_i, .wstrb_i,
    .bvalid_o, .bready_i, .bresp_o,
    .arvalid_i, .arready_o, .araddr_i, .rvalid_o, .rready_i, .rdata_o, .rresp_o,
    .enable_o(enable), .clear_o(clear), .rd_kind_o(rd_kind),
    .count_i(count), .sum_i(sum), .max_i(max), .maxdest_i(maxdest)
  );

endmodule

`default_nettype wire

// ==== logic/rl_sample_if.sv ====
// completed-load sample interface between tracker and statistics, with modports
`default_nettype none

interface rl_sample_if
  import rl_noc_pkg::*;
#(
  parameter int X_W   = 8,
  parameter int Y_W   = 8,
  parameter int LAT_W = 16
) ();

  logic             valid;
  rl_kind_e         kind;
  logic [LAT_W-1:0] latency;
  logic [X_W-1:0]   dest_x;
  logic [Y_W-1:0]   dest_y;

  modport producer (output valid, output kind, output latency, output dest_x, output dest_y);

  // no ready, one sample per cycle is always taken
  modport consumer (input valid, input kind, input latency, input dest_x, input dest_y);

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the profiler testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module rl_profiler_tb -f sources.f -o rl_profiler_sim

./obj_dir/rl_profiler_sim 2>&1 | tee sim.log

if grep -q "tests failed" sim.log; then
  exit 1
fi
exit 0

// ==== sources.f ====
logic/rl_noc_pkg.sv
logic/rl_csr_pkg.sv
logic/rl_sample_if.sv
logic/rl_launch_tracker.sv
logic/rl_latency_stats.sv
logic/rl_axil_csr.sv
logic/rl_profiler_top.sv
verif/rl_profiler_chk.sv
verif/rl_profiler_tb.sv

// ==== verif/rl_profiler_chk.sv ====
// bound assertions on the profiler's AXI4-Lite response channels
`default_nettype none

module rl_profiler_chk
  import rl_csr_pkg::*;
(
  input logic         clk_i,
  input logic         reset_i,
  input logic         bvalid_o,
  input logic         bready_i,
  input logic         rvalid_o,
  input logic         rready_i,
  input logic [31:0]  rdata_o,
  input rl_axi_resp_e rresp_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // a stalled read keeps its data and response
  a_r_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable(rdata_o) && $stable(rresp_o))
    else $error("read data dropped or changed before RREADY");

  a_b_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    bvalid_o && !bready_i |=> bvalid_o)
    else $error("write response dropped before BREADY");

  a_idle_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !bvalid_o && !rvalid_o)
    else $error("response valid high right after reset");

endmodule

bind rl_profiler_top rl_profiler_chk u_chk (
  .clk_i(clk_i),
  .reset_i(reset_i),
  .bvalid_o(bvalid_o),
  .bready_i(bready_i),
  .rvalid_o(rvalid_o),
  .rready_i(rready_i),
  .rdata_o(rdata_o),
  .rresp_o(rresp_o)
);

`default_nettype wire

// ==== verif/rl_profiler_tb.sv ====
// directed testbench for the latency profiler: clock, reset, drivers, reference model, checks
`default_nettype none

module rl_profiler_tb
  import rl_noc_pkg::*;
  import rl_csr_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int REG_ELS = 32;
  localparam int X_W     = 8;
  localparam int Y_W     = 8;
  localparam int LAT_W   = 16;
  localparam int SEED    = 77791;
  // rough per-test cycle budgets, doubled for the watchdog
  localparam int TEST_LEN_SUM   = 150 + 300 + 350 + 350 + 500 + 350;
  localparam int TIMEOUT_CYCLES = 2 * TEST_LEN_SUM;
  localparam int unsigned LAT_MAX = (1 << LAT_W) - 1;

  logic                     clk_i;
  logic                     reset_i;
  logic                     launch_v_i;
  rl_op_e                   launch_op_i;
  logic                     launch_float_wb_i;
  logic                     launch_icache_i;
  logic [4:0]               launch_reg_id_i;
  logic [X_W-1:0]           launch_dest_x_i;
  logic [Y_W-1:0]           launch_dest_y_i;
  logic                     ret_v_i;
  logic                     ret_yumi_i;
  rl_ret_e                  ret_type_i;
  logic [4:0]               ret_reg_id_i;
  logic                     awvalid_i;
  logic                     awready_o;
  logic [RL_CSR_ADDR_W-1:0] awaddr_i;
  logic                     wvalid_i;
  logic                     wready_o;
  logic [31:0]              wdata_i;
  logic [3:0]               wstrb_i;
  logic                     bvalid_o;
  logic                     bready_i;
  rl_axi_resp_e             bresp_o;
  logic                     arvalid_i;
  logic                     arready_o;
  logic [RL_CSR_ADDR_W-1:0] araddr_i;
  logic                     rvalid_o;
  logic                     rready_i;
  logic [31:0]              rdata_o;
  rl_axi_resp_e             rresp_o;

  // reference model state
  int unsigned model_cycle;
  int unsigned int_start [REG_ELS];
  int unsigned float_start [REG_ELS];
  logic [7:0]  int_x [REG_ELS];
  logic [7:0]  int_y [REG_ELS];
  logic [7:0]  float_x [REG_ELS];
  logic [7:0]  float_y [REG_ELS];
  int unsigned ic_start;
  logic [7:0]  ic_x;
  logic [7:0]  ic_y;
  int unsigned m_count [RL_NUM_KINDS];
  int unsigned m_sum [RL_NUM_KINDS];
  int unsigned m_max [RL_NUM_KINDS];
  logic [7:0]  m_maxx [RL_NUM_KINDS];
  logic [7:0]  m_maxy [RL_NUM_KINDS];
  logic        m_enable;

  int errors;
  int checks;
  int tests_run;
  int tests_failed;
  int cycle_count;

  rl_profiler_top #(.REG_ELS(REG_ELS), .X_W(X_W), .Y_W(Y_W), .LAT_W(LAT_W)) UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // mirrors the tracker counter, read on the falling edge when inputs are driven
  always @(posedge clk_i) begin
    if (reset_i) begin
      model_cycle <= 0;
    end else begin
      model_cycle <= model_cycle + 1;
    end
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout after %0d cycles, a handshake never completed", cycle_count);
      $display("tests failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input rl_axi_resp_e got,
                            input rl_axi_resp_e exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s got %s expected %s", $time, name, got.name(), exp.name());
    end
  endtask

  function automatic logic [7:0] stat_addr(input int kind, input int ofs);
    return 8'(16 + 16 * kind + ofs);
  endfunction

  function automatic logic [4:0] rand_reg();
    return 5'($urandom % REG_ELS);
  endfunction

  function automatic logic [7:0] rand_byte();
    return 8'($urandom);
  endfunction

  task automatic model_clear();
    for (int k = 0; k < RL_NUM_KINDS; k++) begin
      m_count[k] = 0;
      m_sum[k]   = 0;
      m_max[k]   = 0;
      m_maxx[k]  = '0;
      m_maxy[k]  = '0;
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           input rl_axi_resp_e exp_resp);
    @(negedge clk_i);
    awvalid_i = 1'b1;
    wvalid_i  = 1'b1;
    awaddr_i  = addr;
    wdata_i   = data;
    wstrb_i   = 4'hF;
    bready_i  = 1'b0;
    while (!(awready_o && wready_o)) @(negedge clk_i);
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    while (!bvalid_o) @(negedge clk_i);
    check_resp($sformatf("bresp_o[0x%02h]", addr), bresp_o, exp_resp);
    // no new write is taken while the response is pending
    check_word("awready_o", {31'b0, awready_o}, 32'd0);
    check_word("wready_o", {31'b0, wready_o}, 32'd0);
    // master stalls the write response
    repeat (2) begin
      @(negedge clk_i);
      check_word("bvalid_o", {31'b0, bvalid_o}, 32'd1);
    end
    bready_i = 1'b1;
    @(negedge clk_i);
    bready_i = 1'b0;
    if (addr == 8'h00) begin
      m_enable = data[0];
      if (data[1]) begin
        model_clear();
      end
    end
  endtask

  task automatic axi_read(input logic [7:0] addr, input int hold_cycles,
                          output logic [31:0] data, output rl_axi_resp_e resp);
    @(negedge clk_i);
    arvalid_i = 1'b1;
    araddr_i  = addr;
    rready_i  = 1'b0;
    while (!arready_o) @(negedge clk_i);
    @(negedge clk_i);
    arvalid_i = 1'b0;
    while (!rvalid_o) @(negedge clk_i);
    check_word("arready_o", {31'b0, arready_o}, 32'd0);
    data = rdata_o;
    resp = rresp_o;
    // master stalls, data must not move
    repeat (hold_cycles) begin
      @(negedge clk_i);
      check_word("rvalid_o", {31'b0, rvalid_o}, 32'd1);
      check_word("rdata_o", rdata_o, data);
    end
    rready_i = 1'b1;
    @(negedge clk_i);
    rready_i = 1'b0;
  endtask

  task automatic read_check(input logic [7:0] addr, input logic [31:0] exp, input string name);
    logic [31:0]  d;
    rl_axi_resp_e r;
    axi_read(addr, 0, d, r);
    check_resp({name, " rresp_o"}, r, RL_AXI_OKAY);
    check_word(name, d, exp);
  endtask

  task automatic check_kind(input int k);
    read_check(stat_addr(k, 0), m_count[k], $sformatf("COUNT[%0d]", k));
    read_check(stat_addr(k, 4), m_sum[k], $sformatf("SUM[%0d]", k));
    read_check(stat_addr(k, 8), m_max[k], $sformatf("MAX[%0d]", k));
    read_check(stat_addr(k, 12), {16'h0, m_maxx[k], m_maxy[k]}, $sformatf("MAXDEST[%0d]", k));
  endtask

  task automatic check_all_kinds();
    for (int k = 0; k < RL_NUM_KINDS; k++) begin
      check_kind(k);
    end
  endtask

  task automatic launch(input rl_op_e op, input logic fwb, input logic ic,
                        input logic [4:0] id, input logic [7:0] x, input logic [7:0] y);
    @(negedge clk_i);
    launch_v_i        = 1'b1;
    launch_op_i       = op;
    launch_float_wb_i = fwb;
    launch_icache_i   = ic;
    launch_reg_id_i   = id;
    launch_dest_x_i   = x;
    launch_dest_y_i   = y;
    if (op == RL_OP_AMO || (op == RL_OP_LOAD && !ic && !fwb)) begin
      int_start[id] = model_cycle;
      int_x[id]     = x;
      int_y[id]     = y;
    end else if (op == RL_OP_LOAD && fwb) begin
      float_start[id] = model_cycle;
      float_x[id]     = x;
      float_y[id]     = y;
    end else if (op == RL_OP_LOAD && ic) begin
      ic_start = model_cycle;
      ic_x     = x;
      ic_y     = y;
    end
    @(negedge clk_i);
    launch_v_i = 1'b0;
  endtask

  task automatic respond(input rl_ret_e typ, input logic [4:0] id);
    int unsigned lat;
    int          k;
    logic [7:0]  x;
    logic [7:0]  y;
    logic        hit;
    @(negedge clk_i);
    ret_v_i      = 1'b1;
    ret_yumi_i   = 1'b1;
    ret_type_i   = typ;
    ret_reg_id_i = id;
    hit = 1'b1;
    k   = 0;
    lat = 0;
    x   = '0;
    y   = '0;
    case (typ)
      RL_RET_INT_WB: begin
        k   = 0;
        lat = model_cycle - int_start[id];
        x   = int_x[id];
        y   = int_y[id];
      end
      RL_RET_FLOAT_WB: begin
        k   = 1;
        lat = model_cycle - float_start[id];
        x   = float_x[id];
        y   = float_y[id];
      end
      RL_RET_IFETCH: begin
        k   = 2;
        lat = model_cycle - ic_start;
        x   = ic_x;
        y   = ic_y;
      end
      default: hit = 1'b0;
    endcase
    if (hit && m_enable) begin
      if (lat > LAT_MAX) begin
        lat = LAT_MAX;
      end
      m_count[k] = m_count[k] + 1;
      m_sum[k]   = m_sum[k] + lat;
      if (lat > m_max[k]) begin
        m_max[k]  = lat;
        m_maxx[k] = x;
        m_maxy[k] = y;
      end
    end
    @(negedge clk_i);
    ret_v_i    = 1'b0;
    ret_yumi_i = 1'b0;
    // sample register, then statistics update
    wait_cycles(2);
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors > err_before) begin
      tests_failed++;
      $display("test %-16s failed with %0d errors", name, errors - err_before);
    end else begin
      $display("test %-16s ok", name);
    end
  endtask

  task automatic test_reset_values();
    int           err0;
    logic [31:0]  d;
    rl_axi_resp_e r;
    err0 = errors;
    read_check(8'h00, 32'h0, "CTRL");
    check_all_kinds();
    axi_read(8'h40, 0, d, r);
    check_resp("rresp_o[0x40]", r, RL_AXI_SLVERR);
    axi_read(8'h04, 0, d, r);
    check_resp("rresp_o[0x04]", r, RL_AXI_SLVERR);
    axi_write(8'h80, 32'h0, RL_AXI_SLVERR);
    finish_test("reset_values", err0);
  endtask

  task automatic test_int_latency();
    int         err0;
    logic [4:0] id;
    err0 = errors;
    axi_write(8'h00, 32'h1, RL_AXI_OKAY);
    repeat (6) begin
      id = rand_reg();
      launch(RL_OP_LOAD, 1'b0, 1'b0, id, rand_byte(), rand_byte());
      wait_cycles(int'($urandom % 12));
      respond(RL_RET_INT_WB, id);
    end
    check_kind(0);
    finish_test("int_latency", err0);
  endtask

  task automatic test_kind_separation();
    int         err0;
    logic [4:0] id;
    err0 = errors;
    id = rand_reg();
    // float and integer loads share a register id
    launch(RL_OP_LOAD, 1'b1, 1'b0, id, 8'h21, 8'h12);
    launch(RL_OP_LOAD, 1'b0, 1'b0, id, 8'h31, 8'h13);
    launch(RL_OP_LOAD, 1'b0, 1'b1, 5'd0, 8'h41, 8'h14);
    wait_cycles(int'($urandom % 8));
    respond(RL_RET_IFETCH, 5'd0);
    respond(RL_RET_FLOAT_WB, id);
    launch(RL_OP_LOAD, 1'b0, 1'b1, 5'd0, 8'h42, 8'h15);
    wait_cycles(int'($urandom % 8) + 5);
    respond(RL_RET_IFETCH, 5'd0);
    respond(RL_RET_INT_WB, id);
    check_all_kinds();
    finish_test("kind_separation", err0);
  endtask

  task automatic test_classification();
    int         err0;
    logic [4:0] id;
    logic [4:0] id2;
    err0 = errors;
    id  = rand_reg();
    id2 = id + 5'd1;
    launch(RL_OP_AMO, 1'b0, 1'b0, id, 8'h51, 8'h16);
    wait_cycles(3);
    respond(RL_RET_INT_WB, id);
    // a store to the same id must not restart the pending load
    launch(RL_OP_LOAD, 1'b0, 1'b0, id2, 8'h52, 8'h17);
    wait_cycles(4);
    launch(RL_OP_STORE, 1'b0, 1'b0, id2, 8'h99, 8'h99);
    wait_cycles(int'($urandom % 6));
    respond(RL_RET_INT_WB, id2);
    respond(RL_RET_CREDIT, id2);
    check_all_kinds();
    finish_test("classification", err0);
  endtask

  task automatic test_enable_clear();
    int         err0;
    logic [4:0] id;
    err0 = errors;
    axi_write(8'h00, 32'h0, RL_AXI_OKAY);
    id = rand_reg();
    launch(RL_OP_LOAD, 1'b0, 1'b0, id, 8'h61, 8'h18);
    wait_cycles(4);
    respond(RL_RET_INT_WB, id);
    launch(RL_OP_LOAD, 1'b1, 1'b0, id, 8'h62, 8'h19);
    respond(RL_RET_FLOAT_WB, id);
    check_all_kinds();
    axi_write(8'h00, 32'h3, RL_AXI_OKAY);
    read_check(8'h00, 32'h1, "CTRL");
    check_all_kinds();
    launch(RL_OP_LOAD, 1'b0, 1'b0, id, 8'h63, 8'h1A);
    wait_cycles(int'($urandom % 6));
    respond(RL_RET_INT_WB, id);
    check_kind(0);
    finish_test("enable_clear", err0);
  endtask

  task automatic test_max_backpressure();
    int           err0;
    int           delays [3];
    logic [4:0]   id;
    logic [31:0]  d;
    rl_axi_resp_e r;
    err0 = errors;
    delays = '{3, 11, 6};
    axi_write(8'h00, 32'h3, RL_AXI_OKAY);
    for (int i = 0; i < 3; i++) begin
      id = rand_reg();
      launch(RL_OP_LOAD, 1'b0, 1'b0, id, rand_byte(), rand_byte());
      wait_cycles(delays[i]);
      respond(RL_RET_INT_WB, id);
    end
    axi_read(stat_addr(0, 12), 6, d, r);
    check_resp("MAXDEST[0] rresp_o", r, RL_AXI_OKAY);
    check_word("MAXDEST[0]", d, {16'h0, m_maxx[0], m_maxy[0]});
    check_kind(0);
    finish_test("max_backpressure", err0);
  endtask

  initial begin
    void'($urandom(SEED));
    reset_i           = 1'b1;
    launch_v_i        = 1'b0;
    launch_op_i       = RL_OP_LOAD;
    launch_float_wb_i = 1'b0;
    launch_icache_i   = 1'b0;
    launch_reg_id_i   = '0;
    launch_dest_x_i   = '0;
    launch_dest_y_i   = '0;
    ret_v_i           = 1'b0;
    ret_yumi_i        = 1'b0;
    ret_type_i        = RL_RET_CREDIT;
    ret_reg_id_i      = '0;
    awvalid_i         = 1'b0;
    awaddr_i          = '0;
    wvalid_i          = 1'b0;
    wdata_i           = '0;
    wstrb_i           = '0;
    bready_i          = 1'b0;
    arvalid_i         = 1'b0;
    araddr_i          = '0;
    rready_i          = 1'b0;
    errors            = 0;
    checks            = 0;
    tests_run         = 0;
    tests_failed      = 0;
    cycle_count       = 0;
    m_enable          = 1'b0;
    model_clear();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;

    test_reset_values();
    test_int_latency();
    test_kind_separation();
    test_classification();
    test_enable_clear();
    test_max_backpressure();

    $display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
